// ==== include/rv_board_bus_defs.svh ====
`ifndef RV_BOARD_BUS_DEFS_SVH
`define RV_BOARD_BUS_DEFS_SVH

// data RAM window
`define RAM_BASE 64'h0000_0000_0000_1000
`define RAM_BYTES 4096
// depth in 32-bit words
`define RAM_WORDS 1024

// keyboard data register, read only
`define KEY_ADDR 64'h0000_0000_0000_2000
// console write register
`define UART_ADDR 64'h0000_0000_0000_2008

// sd card control and status
`define SDC_ADDR 64'h0000_0000_0000_3000
`define SDC_READ 64'h0000_0000_0000_3008
`define SDC_READY 64'h0000_0000_0000_3010
`define SDC_AVAIL 64'h0000_0000_0000_3018

// sector buffer window, one byte per address
`define SDC_BASE 64'h0000_0000_0000_4000
`define SDC_BYTES 512

`endif

// ==== source/rv_board_bus_pkg.sv ====
package rv_board_bus_pkg;

    // bus side
    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;

    // one ram word
    typedef logic [31:0] mem_word_t;

    // bit 2 unsigned on loads
    // low bits 00 byte, 01 half, 10 word, 11 double
    typedef logic [2:0] ls_type_t;

    // sd card side
    typedef logic [7:0] sd_byte_t;
    typedef logic [31:0] sd_sector_addr_t;
    typedef logic [8:0] sdc_index_t;

    typedef logic [3:0] irq_vector_t;

    // double access runs over two beats
    typedef enum logic {
        beat_first,
        beat_second
    } beat_t;

endpackage

// ==== source/addr_decoder.sv ====
`timescale 1ns/100ps
`include "rv_board_bus_defs.svh"

module addr_decoder (
    input  rv_board_bus_pkg::bus_addr_t  bus_address,
    output logic                         sel_ram,
    output logic                         sel_key,
    output logic                         sel_uart,
    output logic                         sel_sdc_addr,
    output logic                         sel_sdc_read,
    output logic                         sel_sdc_ready,
    output logic                         sel_sdc_avail,
    output logic                         sel_sdc_buf,
    output rv_board_bus_pkg::sdc_index_t sdc_index
);

    // byte offset into the sector buffer window
    rv_board_bus_pkg::bus_addr_t buf_offset;

    // ram range
    assign sel_ram = (bus_address >= `RAM_BASE) &&
                     (bus_address < (`RAM_BASE + `RAM_BYTES));

    // single registers
    assign sel_key       = (bus_address == `KEY_ADDR);
    assign sel_uart      = (bus_address == `UART_ADDR);
    assign sel_sdc_addr  = (bus_address == `SDC_ADDR);
    assign sel_sdc_read  = (bus_address == `SDC_READ);
    assign sel_sdc_ready = (bus_address == `SDC_READY);
    assign sel_sdc_avail = (bus_address == `SDC_AVAIL);

    // sector buffer range
    assign sel_sdc_buf = (bus_address >= `SDC_BASE) &&
                         (bus_address < (`SDC_BASE + `SDC_BYTES));

    assign buf_offset = bus_address - `SDC_BASE;
    // window is 512 bytes, low bits are the index
    assign sdc_index = buf_offset[$bits(rv_board_bus_pkg::sdc_index_t)-1:0];

endmodule

// ==== source/word_ram.sv ====
`timescale 1ns/100ps
`include "rv_board_bus_defs.svh"

module word_ram (
    input  logic                        CLOCK_50,
    input  logic                        KEY0,
    input  logic                        ram_read,
    input  logic                        ram_write,
    input  rv_board_bus_pkg::bus_addr_t bus_address,
    input  rv_board_bus_pkg::ls_type_t  bus_ls_type,
    input  rv_board_bus_pkg::bus_data_t bus_write_data,
    output rv_board_bus_pkg::bus_data_t ram_rdata,
    output logic                        ram_last
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    rv_board_bus_pkg::mem_word_t mem [`RAM_WORDS];

    rv_board_bus_pkg::beat_t     beat;
    rv_board_bus_pkg::bus_addr_t ram_offset;
    logic [IDX_W-1:0]            word_idx;
    logic [IDX_W-1:0]            beat_idx;
    logic [1:0]                  byte_off;
    logic                        is_double;
    rv_board_bus_pkg::mem_word_t cur_word;
    rv_board_bus_pkg::mem_word_t shifted;
    rv_board_bus_pkg::mem_word_t store_word;
    rv_board_bus_pkg::mem_word_t low_word;

    assign ram_offset = bus_address - `RAM_BASE;
    assign word_idx   = ram_offset[IDX_W+1:2];
    assign byte_off   = ram_offset[1:0];
    assign is_double  = (bus_ls_type[1:0] == 2'b11);

    // second beat of a double goes to the next word
    assign beat_idx = (beat == rv_board_bus_pkg::beat_second) ? word_idx + 1'b1 : word_idx;
    assign cur_word = mem[beat_idx];
    assign ram_last = !is_double || (beat == rv_board_bus_pkg::beat_second);

    // loads come back shifted down to bit 0
    assign shifted = cur_word >> {byte_off, 3'b000};

    always_comb begin
        case (bus_ls_type[1:0])
            2'b00:   ram_rdata = {56'd0, shifted[7:0]};
            2'b01:   ram_rdata = {48'd0, shifted[15:0]};
            2'b10:   ram_rdata = {32'd0, shifted};
            // double, valid in the second beat only
            default: ram_rdata = {cur_word, low_word};
        endcase
    end

    // merge the store into the addressed word
    always_comb begin
        store_word = cur_word;
        case (bus_ls_type[1:0])
            2'b00:   store_word[{byte_off, 3'b000} +: 8] = bus_write_data[7:0];
            // halves sit on lane 0 or lane 2
            2'b01:   store_word[{byte_off[1], 4'b0000} +: 16] = bus_write_data[15:0];
            2'b10:   store_word = bus_write_data[31:0];
            default: begin
                if (beat == rv_board_bus_pkg::beat_second) begin
                    store_word = bus_write_data[63:32];
                end else begin
                    store_word = bus_write_data[31:0];
                end
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_write) begin
            mem[beat_idx] <= store_word;
        end
        // hold low half of a double load
        if (ram_read && (beat == rv_board_bus_pkg::beat_first)) begin
            low_word <= cur_word;
        end
    end

    // beat tracker, toggles only on doubles
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat <= rv_board_bus_pkg::beat_first;
        end else if ((ram_read || ram_write) && is_double) begin
            if (beat == rv_board_bus_pkg::beat_first) begin
                beat <= rv_board_bus_pkg::beat_second;
            end else begin
                beat <= rv_board_bus_pkg::beat_first;
            end
        end
    end

endmodule

// ==== source/sd_sector_buffer.sv ====
`timescale 1ns/100ps
`include "rv_board_bus_defs.svh"

module sd_sector_buffer (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         sd_byte_available,
    input  rv_board_bus_pkg::sd_byte_t   sd_dout,
    input  rv_board_bus_pkg::sdc_index_t sdc_index,
    output rv_board_bus_pkg::sd_byte_t   sdc_byte,
    output logic                         sdc_available
);

    rv_board_bus_pkg::sd_byte_t buffer [`SDC_BYTES];

    rv_board_bus_pkg::sdc_index_t fill_idx;
    logic                         byte_avail_d;
    logic                         byte_rise;
    logic                         sector_done;

    // one byte per rising edge of the strobe
    assign byte_rise = sd_byte_available && !byte_avail_d;

    always_ff @(posedge CLOCK_50) begin
        if (byte_rise) begin
            buffer[fill_idx] <= sd_dout;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            byte_avail_d  <= 1'b0;
            fill_idx      <= '0;
            sector_done   <= 1'b0;
            sdc_available <= 1'b0;
        end else begin
            byte_avail_d <= sd_byte_available;
            // set one cycle after the last byte lands
            sector_done  <= byte_rise && (fill_idx == '1);
            if (byte_rise) begin
                // 9-bit index wraps after 512
                fill_idx <= fill_idx + 1'b1;
            end
            if (sector_done) begin
                sdc_available <= 1'b1;
            end else if (byte_rise && (fill_idx == '0)) begin
                // next sector has started
                sdc_available <= 1'b0;
            end
        end
    end

    // bus read port
    assign sdc_byte = buffer[sdc_index];

endmodule

// ==== source/key_irq.sv ====
`timescale 1ns/100ps

module key_irq (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  logic                          key_pressed,
    input  logic                          int_ack,
    input  rv_board_bus_pkg::sd_byte_t    key_ascii,
    output rv_board_bus_pkg::sd_byte_t    key_code,
    output rv_board_bus_pkg::irq_vector_t int_vector
);

    logic key_pressed_d;
    logic key_rise;

    assign key_rise = key_pressed && !key_pressed_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_pressed_d <= 1'b0;
            key_code      <= '0;
            int_vector    <= '0;
        end else begin
            key_pressed_d <= key_pressed;
            // latch code on every new press
            if (key_rise) begin
                key_code <= key_ascii;
            end
            // ack wins over a new press
            if (int_ack) begin
                int_vector <= '0;
            end else if (key_rise && (key_ascii != '0)) begin
                // keyboard is vector 1
                int_vector <= rv_board_bus_pkg::irq_vector_t'(1);
            end
        end
    end

endmodule

// ==== source/bus_responder.sv ====
`timescale 1ns/100ps

module bus_responder (
    input  logic                             CLOCK_50,
    input  logic                             KEY0,
    input  logic                             bus_read_enable,
    input  logic                             bus_write_enable,
    input  rv_board_bus_pkg::bus_data_t      bus_write_data,
    input  logic                             sel_ram,
    input  logic                             sel_key,
    input  logic                             sel_uart,
    input  logic                             sel_sdc_addr,
    input  logic                             sel_sdc_read,
    input  logic                             sel_sdc_ready,
    input  logic                             sel_sdc_avail,
    input  logic                             sel_sdc_buf,
    input  rv_board_bus_pkg::bus_data_t      ram_rdata,
    input  logic                             ram_last,
    input  rv_board_bus_pkg::sd_byte_t       key_code,
    input  rv_board_bus_pkg::sd_byte_t       sdc_byte,
    input  logic                             sdc_available,
    input  logic                             sd_ready,
    output logic                             ram_read,
    output logic                             ram_write,
    output rv_board_bus_pkg::bus_data_t      bus_read_data,
    output logic                             bus_read_done,
    output logic                             bus_write_done,
    output rv_board_bus_pkg::sd_sector_addr_t sd_addr,
    output logic                             sd_rd_start,
    output logic                             uart_write,
    output rv_board_bus_pkg::mem_word_t      uart_data
);

    logic                        read_beat;
    logic                        write_beat;
    logic                        read_finish;
    logic                        write_finish;
    rv_board_bus_pkg::bus_data_t read_value;

    // service beat: enable gone, done still low
    assign read_beat  = !bus_read_enable && !bus_read_done;
    assign write_beat = !bus_write_enable && !bus_write_done;

    assign ram_read  = read_beat && sel_ram;
    assign ram_write = write_beat && sel_ram;

    // ram may need a second beat, everything else finishes at once
    assign read_finish  = read_beat && (!sel_ram || ram_last);
    assign write_finish = write_beat && (!sel_ram || ram_last);

    // unmapped and write-only addresses read zero
    always_comb begin
        if (sel_ram) begin
            read_value = ram_rdata;
        end else if (sel_key) begin
            read_value = {56'd0, key_code};
        end else if (sel_sdc_ready) begin
            read_value = {63'd0, sd_ready};
        end else if (sel_sdc_avail) begin
            read_value = {63'd0, sdc_available};
        end else if (sel_sdc_buf) begin
            read_value = {56'd0, sdc_byte};
        end else begin
            read_value = '0;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
            sd_addr        <= '0;
            sd_rd_start    <= 1'b0;
            uart_write     <= 1'b0;
        end else begin
            // strobes last one cycle
            sd_rd_start <= 1'b0;
            uart_write  <= 1'b0;
            if (bus_read_enable) begin
                bus_read_done <= 1'b0;
            end
            if (bus_write_enable) begin
                bus_write_done <= 1'b0;
            end
            if (read_finish) begin
                bus_read_data <= read_value;
                bus_read_done <= 1'b1;
            end
            if (write_finish) begin
                bus_write_done <= 1'b1;
                if (sel_sdc_addr) begin
                    sd_addr <= bus_write_data[31:0];
                end
                if (sel_sdc_read) begin
                    sd_rd_start <= 1'b1;
                end
                if (sel_uart) begin
                    uart_write <= 1'b1;
                end
            end
        end
    end

    // console data, valid while uart_write is high
    always_ff @(posedge CLOCK_50) begin
        if (write_finish && sel_uart) begin
            uart_data <= bus_write_data[31:0];
        end
    end

endmodule

// ==== source/rv_board_bus.sv ====
`timescale 1ns/100ps

module rv_board_bus (
    input  logic                              CLOCK_50,
    input  logic                              KEY0,
    // master side
    input  rv_board_bus_pkg::bus_addr_t       bus_address,
    input  rv_board_bus_pkg::ls_type_t        bus_ls_type,
    input  logic                              bus_read_enable,
    input  logic                              bus_write_enable,
    input  rv_board_bus_pkg::bus_data_t       bus_write_data,
    output rv_board_bus_pkg::bus_data_t       bus_read_data,
    output logic                              bus_read_done,
    output logic                              bus_write_done,
    // keyboard
    input  logic                              key_pressed,
    input  rv_board_bus_pkg::sd_byte_t        key_ascii,
    input  logic                              int_ack,
    output rv_board_bus_pkg::irq_vector_t     int_vector,
    // sd controller
    input  rv_board_bus_pkg::sd_byte_t        sd_dout,
    input  logic                              sd_byte_available,
    input  logic                              sd_ready,
    output rv_board_bus_pkg::sd_sector_addr_t sd_addr,
    output logic                              sd_rd_start,
    // console
    output logic                              uart_write,
    output rv_board_bus_pkg::mem_word_t       uart_data
);

    logic sel_ram;
    logic sel_key;
    logic sel_uart;
    logic sel_sdc_addr;
    logic sel_sdc_read;
    logic sel_sdc_ready;
    logic sel_sdc_avail;
    logic sel_sdc_buf;
    logic ram_read;
    logic ram_write;
    logic ram_last;
    logic sdc_available;

    rv_board_bus_pkg::sdc_index_t sdc_index;
    rv_board_bus_pkg::bus_data_t  ram_rdata;
    rv_board_bus_pkg::sd_byte_t   key_code;
    rv_board_bus_pkg::sd_byte_t   sdc_byte;

    addr_decoder i_addr_decoder (
        .bus_address   (bus_address),
        .sel_ram       (sel_ram),
        .sel_key       (sel_key),
        .sel_uart      (sel_uart),
        .sel_sdc_addr  (sel_sdc_addr),
        .sel_sdc_read  (sel_sdc_read),
        .sel_sdc_ready (sel_sdc_ready),
        .sel_sdc_avail (sel_sdc_avail),
        .sel_sdc_buf   (sel_sdc_buf),
        .sdc_index     (sdc_index)
    );

    word_ram i_word_ram (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .ram_read       (ram_read),
        .ram_write      (ram_write),
        .bus_address    (bus_address),
        .bus_ls_type    (bus_ls_type),
        .bus_write_data (bus_write_data),
        .ram_rdata      (ram_rdata),
        .ram_last       (ram_last)
    );

    sd_sector_buffer i_sd_sector_buffer (
        .CLOCK_50          (CLOCK_50),
        .KEY0              (KEY0),
        .sd_byte_available (sd_byte_available),
        .sd_dout           (sd_dout),
        .sdc_index         (sdc_index),
        .sdc_byte          (sdc_byte),
        .sdc_available     (sdc_available)
    );

    key_irq i_key_irq (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_pressed (key_pressed),
        .int_ack     (int_ack),
        .key_ascii   (key_ascii),
        .key_code    (key_code),
        .int_vector  (int_vector)
    );

    bus_responder i_bus_responder (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_write_data   (bus_write_data),
        .sel_ram          (sel_ram),
        .sel_key          (sel_key),
        .sel_uart         (sel_uart),
        .sel_sdc_addr     (sel_sdc_addr),
        .sel_sdc_read     (sel_sdc_read),
        .sel_sdc_ready    (sel_sdc_ready),
        .sel_sdc_avail    (sel_sdc_avail),
        .sel_sdc_buf      (sel_sdc_buf),
        .ram_rdata        (ram_rdata),
        .ram_last         (ram_last),
        .key_code         (key_code),
        .sdc_byte         (sdc_byte),
        .sdc_available    (sdc_available),
        .sd_ready         (sd_ready),
        .ram_read         (ram_read),
        .ram_write        (ram_write),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .sd_addr          (sd_addr),
        .sd_rd_start      (sd_rd_start),
        .uart_write       (uart_write),
        .uart_data        (uart_data)
    );

endmodule

// ==== dv/rv_board_bus_checker.sv ====
`timescale 1ns/100ps
`include "rv_board_bus_defs.svh"

module rv_board_bus_checker (
    input logic                          CLOCK_50,
    input logic                          KEY0,
    input rv_board_bus_pkg::bus_addr_t   bus_address,
    input rv_board_bus_pkg::ls_type_t    bus_ls_type,
    input logic                          bus_read_enable,
    input logic                          bus_write_enable,
    input logic                          bus_read_done,
    input logic                          bus_write_done,
    input logic                          sd_rd_start,
    input logic                          uart_write,
    input logic                          int_ack,
    input rv_board_bus_pkg::irq_vector_t int_vector
);

    // read from the testbench at the end of the run
    int   fail_count = 0;
    logic ram_double;

    // only a double into ram takes two beats
    assign ram_double = (bus_ls_type[1:0] == 2'b11) && (bus_address >= `RAM_BASE) &&
                        (bus_address < (`RAM_BASE + `RAM_BYTES));

    read_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable && !ram_double |=> !bus_read_done ##1 bus_read_done)
        else begin
            $error("read done not back one cycle after enable");
            fail_count++;
        end

    read_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable && ram_double |=> !bus_read_done ##1 !bus_read_done ##1 bus_read_done)
        else begin
            $error("double read done not back two cycles after enable");
            fail_count++;
        end

    write_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable && !ram_double |=> !bus_write_done ##1 bus_write_done)
        else begin
            $error("write done not back one cycle after enable");
            fail_count++;
        end

    write_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable && ram_double |=> !bus_write_done ##1 !bus_write_done ##1 bus_write_done)
        else begin
            $error("double write done not back two cycles after enable");
            fail_count++;
        end

    // strobes are single cycle
    rd_start_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start)
        else begin
            $error("sd_rd_start held for two cycles");
            fail_count++;
        end

    uart_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |=> !uart_write)
        else begin
            $error("uart_write held for two cycles");
            fail_count++;
        end

    // ack clears the vector at once
    ack_clears: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        int_ack |=> (int_vector == '0))
        else begin
            $error("int_vector still set after int_ack");
            fail_count++;
        end

endmodule

bind rv_board_bus rv_board_bus_checker i_rv_board_bus_checker (
    .CLOCK_50         (CLOCK_50),
    .KEY0             (KEY0),
    .bus_address      (bus_address),
    .bus_ls_type      (bus_ls_type),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable),
    .bus_read_done    (bus_read_done),
    .bus_write_done   (bus_write_done),
    .sd_rd_start      (sd_rd_start),
    .uart_write       (uart_write),
    .int_ack          (int_ack),
    .int_vector       (int_vector)
);

// ==== dv/tb_rv_board_bus.sv ====
`timescale 1ns/100ps
`include "rv_board_bus_defs.svh"

module tb_rv_board_bus;

    // cycles a bus access may take before giving up
    localparam int DONE_LIMIT = 16;
    localparam rv_board_bus_pkg::bus_addr_t UNMAPPED = 64'h0000_0000_0000_8000;

    logic CLOCK_50 = 1'b0;
    logic KEY0;
    rv_board_bus_pkg::bus_addr_t       bus_address;
    rv_board_bus_pkg::ls_type_t        bus_ls_type;
    logic                              bus_read_enable;
    logic                              bus_write_enable;
    rv_board_bus_pkg::bus_data_t       bus_write_data;
    rv_board_bus_pkg::bus_data_t       bus_read_data;
    logic                              bus_read_done;
    logic                              bus_write_done;
    logic                              key_pressed;
    rv_board_bus_pkg::sd_byte_t        key_ascii;
    logic                              int_ack;
    rv_board_bus_pkg::irq_vector_t     int_vector;
    rv_board_bus_pkg::sd_byte_t        sd_dout;
    logic                              sd_byte_available;
    logic                              sd_ready;
    rv_board_bus_pkg::sd_sector_addr_t sd_addr;
    logic                              sd_rd_start;
    logic                              uart_write;
    rv_board_bus_pkg::mem_word_t       uart_data;

    // reference model of ram bytes and the last sector sent
    logic [7:0] ram_model [`RAM_BYTES];
    logic [7:0] sector_model [`SDC_BYTES];

    int errors = 0;
    int rd_start_count = 0;
    int uart_count = 0;
    rv_board_bus_pkg::mem_word_t uart_seen;

    rv_board_bus i_rv_board_bus (.*);

    always #50 CLOCK_50 = ~CLOCK_50;

    // strobe monitor samples mid-cycle
    always @(negedge CLOCK_50) begin
        if (sd_rd_start) begin
            rd_start_count++;
        end
        if (uart_write) begin
            uart_count++;
            uart_seen = uart_data;
        end
    end

    task automatic compare_data(input rv_board_bus_pkg::bus_data_t got,
                                input rv_board_bus_pkg::bus_data_t exp, input string what);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s within %0d cycles", what, DONE_LIMIT);
        $display("Test failed");
        $finish;
    endtask

    task automatic bus_write(input rv_board_bus_pkg::bus_addr_t addr,
                             input rv_board_bus_pkg::ls_type_t ls,
                             input rv_board_bus_pkg::bus_data_t wdata, output int beats);
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_ls_type      = ls;
        bus_write_data   = wdata;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        beats = 0;
        while (!bus_write_done && beats < DONE_LIMIT) begin
            @(negedge CLOCK_50);
            beats++;
        end
        if (!bus_write_done) begin
            abort_on_timeout("bus write done did not return");
        end
    endtask

    task automatic bus_read(input rv_board_bus_pkg::bus_addr_t addr,
                            input rv_board_bus_pkg::ls_type_t ls,
                            output rv_board_bus_pkg::bus_data_t rdata, output int beats);
        @(negedge CLOCK_50);
        bus_address     = addr;
        bus_ls_type     = ls;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        beats = 0;
        while (!bus_read_done && beats < DONE_LIMIT) begin
            @(negedge CLOCK_50);
            beats++;
        end
        if (!bus_read_done) begin
            abort_on_timeout("bus read done did not return");
        end
        rdata = bus_read_data;
    endtask

    // stores 1 << ls[1:0] little endian bytes
    task automatic ram_store(input rv_board_bus_pkg::bus_addr_t addr,
                             input rv_board_bus_pkg::ls_type_t ls,
                             input rv_board_bus_pkg::bus_data_t wdata);
        int beats;
        int off;
        bus_write(addr, ls, wdata, beats);
        compare_data(beats, (ls[1:0] == 2'b11) ? 2 : 1, "ram store beats");
        off = addr - `RAM_BASE;
        for (int i = 0; i < (1 << ls[1:0]); i++) begin
            ram_model[off + i] = wdata[i*8 +: 8];
        end
    endtask

    // expected value is shifted down and zero filled
    task automatic ram_load(input rv_board_bus_pkg::bus_addr_t addr,
                            input rv_board_bus_pkg::ls_type_t ls);
        rv_board_bus_pkg::bus_data_t exp;
        rv_board_bus_pkg::bus_data_t got;
        int beats;
        int off;
        exp = '0;
        off = addr - `RAM_BASE;
        for (int i = 0; i < (1 << ls[1:0]); i++) begin
            exp[i*8 +: 8] = ram_model[off + i];
        end
        bus_read(addr, ls, got, beats);
        compare_data(got, exp, "ram load data");
        compare_data(beats, (ls[1:0] == 2'b11) ? 2 : 1, "ram load beats");
    endtask

    task automatic feed_sd_byte(input rv_board_bus_pkg::sd_byte_t value);
        @(negedge CLOCK_50);
        sd_dout           = value;
        sd_byte_available = 1'b1;
        @(negedge CLOCK_50);
        sd_byte_available = 1'b0;
    endtask

    initial begin
        rv_board_bus_pkg::bus_addr_t base;
        rv_board_bus_pkg::bus_data_t data;
        rv_board_bus_pkg::bus_data_t rdata;
        rv_board_bus_pkg::sd_byte_t  code;
        int beats;
        int prev;
        int chk_fails;
        void'($urandom(32'he12b));
        KEY0              = 1'b0;
        bus_address       = '0;
        bus_ls_type       = '0;
        bus_read_enable   = 1'b0;
        bus_write_enable  = 1'b0;
        bus_write_data    = '0;
        key_pressed       = 1'b0;
        key_ascii         = '0;
        int_ack           = 1'b0;
        sd_dout           = '0;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        repeat (5) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        compare_data({bus_read_done, bus_write_done}, 2'b11, "done flags after reset");

        // ram round trips start with a double so all 8 bytes are known
        for (int t = 0; t < 8; t++) begin
            base = `RAM_BASE + ($urandom % (`RAM_BYTES / 8)) * 8;
            ram_store(base, 3'b011, {$urandom, $urandom});
            ram_load(base, 3'b011);
            ram_store(base + ($urandom % 8), 3'b000, {$urandom, $urandom});
            ram_store(base + ($urandom % 4) * 2, 3'b001, {$urandom, $urandom});
            ram_store(base + ($urandom % 2) * 4, 3'b010, {$urandom, $urandom});
            ram_load(base, 3'b011);
            ram_load(base, 3'b110);
            ram_load(base + 4, 3'b110);
            for (int o = 0; o < 8; o += 2) begin
                ram_load(base + o, 3'b101);
            end
            for (int o = 0; o < 8; o++) begin
                ram_load(base + o, 3'b100);
            end
        end

        // keyboard press followed by readback and ack
        code = 8'h21 + ($urandom % 8'h5e);
        @(negedge CLOCK_50);
        key_ascii   = code;
        key_pressed = 1'b1;
        @(negedge CLOCK_50);
        compare_data(int_vector, 1, "int_vector after key press");
        bus_read(`KEY_ADDR, 3'b110, rdata, beats);
        compare_data(rdata, {56'd0, code}, "key code read");
        @(negedge CLOCK_50);
        int_ack = 1'b1;
        @(negedge CLOCK_50);
        int_ack     = 1'b0;
        key_pressed = 1'b0;
        compare_data(int_vector, 0, "int_vector after ack");
        // zero code raises nothing
        @(negedge CLOCK_50);
        key_ascii   = '0;
        key_pressed = 1'b1;
        repeat (2) @(negedge CLOCK_50);
        key_pressed = 1'b0;
        compare_data(int_vector, 0, "int_vector after zero code");

        // one full sector
        for (int i = 0; i < `SDC_BYTES; i++) begin
            sector_model[i] = $urandom;
            feed_sd_byte(sector_model[i]);
        end
        bus_read(`SDC_AVAIL, 3'b110, rdata, beats);
        compare_data(rdata, 1, "sector available after 512 bytes");
        for (int i = 0; i < `SDC_BYTES; i++) begin
            bus_read(`SDC_BASE + i, 3'b100, rdata, beats);
            compare_data(rdata, {56'd0, sector_model[i]}, "sector buffer byte");
        end
        feed_sd_byte($urandom);
        bus_read(`SDC_AVAIL, 3'b110, rdata, beats);
        compare_data(rdata, 0, "sector available after next sector start");
        sd_ready = 1'b1;
        bus_read(`SDC_READY, 3'b110, rdata, beats);
        compare_data(rdata, 1, "sd ready high");
        sd_ready = 1'b0;
        bus_read(`SDC_READY, 3'b110, rdata, beats);
        compare_data(rdata, 0, "sd ready low");

        // peripheral writes and strobes
        data = {$urandom, $urandom};
        bus_write(`SDC_ADDR, 3'b011, data, beats);
        compare_data(beats, 1, "sector address write beats");
        @(negedge CLOCK_50);
        compare_data(sd_addr, data[31:0], "sd_addr");
        prev = rd_start_count;
        bus_write(`SDC_READ, 3'b010, {$urandom, $urandom}, beats);
        repeat (2) @(negedge CLOCK_50);
        compare_data(rd_start_count, prev + 1, "sd_rd_start pulse count");
        prev = uart_count;
        data = {$urandom, $urandom};
        bus_write(`UART_ADDR, 3'b010, data, beats);
        repeat (2) @(negedge CLOCK_50);
        compare_data(uart_count, prev + 1, "uart_write pulse count");
        compare_data(uart_seen, data[31:0], "uart_data during strobe");

        // ram data left on the bus has to be replaced by the unmapped zero
        ram_load(base, 3'b011);
        bus_read(UNMAPPED, 3'b011, rdata, beats);
        compare_data(rdata, 0, "unmapped read data");
        compare_data(beats, 1, "unmapped read beats");
        // ram still answers afterwards
        ram_load(base, 3'b011);

        repeat (2) @(negedge CLOCK_50);
        chk_fails = i_rv_board_bus.i_rv_board_bus_checker.fail_count;
        $display("errors: %0d testbench, %0d checker", errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== rv_board_bus.f ====
+incdir+include
source/rv_board_bus_pkg.sv
source/addr_decoder.sv
source/word_ram.sv
source/sd_sector_buffer.sv
source/key_irq.sv
source/bus_responder.sv
source/rv_board_bus.sv
dv/rv_board_bus_checker.sv
dv/tb_rv_board_bus.sv
